// File: rtl/memctl_macros.svh
// Sizing macros for data groups, lane width, address width, burst length and read latency
`ifndef MEMCTL_MACROS_SVH
`define MEMCTL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Data path geometry
//////////////////////////////////////////////////////////////////////

// Number of data groups, each with its own latency and lane
`define MEMCTL_NUM_GROUPS 4

// Width of the data lane owned by one group
`define MEMCTL_LANE_W 9

// Width of a burst address on the memory command bus
`define MEMCTL_ADDR_W 10

//////////////////////////////////////////////////////////////////////
// Burst and latency limits
//////////////////////////////////////////////////////////////////////

// Beats per burst, which is also the closest spacing of two commands
`define MEMCTL_BURST_LENGTH 4

// Highest read latency in cycles and the depth of the shifter tap chain
`define MEMCTL_MAX_LATENCY 12

// Width of one group's latency setting, wide enough for MEMCTL_MAX_LATENCY
`define MEMCTL_LAT_W 4

`endif

// File: rtl/memctl_pkg.sv
// Package with the lane, word, request, command, configuration and read beat types
`include "memctl_macros.svh"

package memctl_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data words
	//////////////////////////////////////////////////////////////////////

	// One group's slice of a beat
	typedef logic [`MEMCTL_LANE_W-1:0] lane_t;

	// A full beat made of all lanes, group 0 sits in the low bits
	typedef lane_t [`MEMCTL_NUM_GROUPS-1:0] word_t;

	//////////////////////////////////////////////////////////////////////
	// Request and command buses
	//////////////////////////////////////////////////////////////////////

	// User burst request, a set wr wins over a set rd
	typedef struct packed {
		logic                                rd;
		logic                                wr;
		logic [`MEMCTL_ADDR_W-1:0]           addr;
		word_t [`MEMCTL_BURST_LENGTH-1:0]    wdata;
	} user_req_t;

	// Memory command bus, wbeat carries one write beat per cycle of a write burst
	typedef struct packed {
		logic                                rd;
		logic                                wr;
		logic [`MEMCTL_ADDR_W-1:0]           addr;
		word_t                               wbeat;
	} mem_cmd_t;

	// Static calibration result, one read latency per group
	typedef struct packed {
		logic [`MEMCTL_NUM_GROUPS-1:0][`MEMCTL_LAT_W-1:0] latency;
	} group_cfg_t;

	//////////////////////////////////////////////////////////////////////
	// Read return
	//////////////////////////////////////////////////////////////////////

	// One captured beat of a single lane
	typedef struct packed {
		logic  valid;
		lane_t data;
	} lane_beat_t;

	// Aligned read word handed to the user
	typedef struct packed {
		logic  valid;
		word_t data;
	} rd_out_t;

endpackage

// File: rtl/memctl_cmd_issue.sv
// Command issuer with request acceptance, burst spacing, write beat serialiser and read strobe
`include "memctl_macros.svh"

module memctl_cmd_issue (
	input  logic                  clk,
	input  logic                  reset_n,
	input  memctl_pkg::user_req_t req,
	output logic                  ready,
	output memctl_pkg::mem_cmd_t  mem_cmd,
	output logic                  rd_strobe
);

	localparam int BL    = `MEMCTL_BURST_LENGTH;
	localparam int CNT_W = (BL > 2) ? $clog2(BL) : 1;

	// Cycles left before the next request may be taken
	logic [CNT_W-1:0]               space_cnt;
	// Index of the write beat now on the bus
	logic [CNT_W-1:0]               beat_idx;
	logic                           wr_active;
	logic                           cmd_rd;
	logic                           cmd_wr;
	logic [`MEMCTL_ADDR_W-1:0]      cmd_addr;
	memctl_pkg::word_t [BL-1:0]     wdata_q;
	logic                           accept;

	// A request counts only when one of its strobes is set and we are idle
	assign accept = ready && (req.rd || req.wr);
	assign ready  = (space_cnt == '0);

	//////////////////////////////////////////////////////////////////////
	// Burst spacing
	//////////////////////////////////////////////////////////////////////

	// Loading BL-1 puts consecutive commands exactly BL cycles apart,
	// so write bursts stream back to back without overlap
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			space_cnt <= '0;
		else if (accept)
			space_cnt <= CNT_W'(BL - 1);
		else if (space_cnt != '0)
			space_cnt <= space_cnt - 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Command register
	//////////////////////////////////////////////////////////////////////

	// Strobes are single cycle, a request with both set is issued as a write
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cmd_rd <= 1'b0;
			cmd_wr <= 1'b0;
		end
		else
		begin
			cmd_rd <= accept && req.rd && !req.wr;
			cmd_wr <= accept && req.wr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			cmd_addr <= req.addr;
	end

	//////////////////////////////////////////////////////////////////////
	// Write beat serialiser
	//////////////////////////////////////////////////////////////////////

	// Streaming starts together with the write command and lasts BL beats
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_active <= 1'b0;
			beat_idx  <= '0;
		end
		else if (accept)
		begin
			wr_active <= req.wr;
			beat_idx  <= '0;
		end
		else if (wr_active)
		begin
			if (beat_idx == CNT_W'(BL - 1))
				wr_active <= 1'b0;
			beat_idx <= beat_idx + 1'b1;
		end
	end

	// Burst data moves down one word per beat, word 0 is always on the bus
	always_ff @(posedge clk)
	begin
		if (accept)
			wdata_q <= req.wdata;
		else if (wr_active)
		begin
			for (int i = 0; i < BL - 1; i++)
				wdata_q[i] <= wdata_q[i+1];
		end
	end

	always_comb
	begin
		mem_cmd.rd    = cmd_rd;
		mem_cmd.wr    = cmd_wr;
		mem_cmd.addr  = cmd_addr;
		mem_cmd.wbeat = wr_active ? wdata_q[0] : '0;
	end

	// Every group starts its latency count from the read command cycle
	assign rd_strobe = cmd_rd;

endmodule

// File: rtl/memctl_burst_latency_shifter.sv
// Burst latency shifter with pulse stretcher and tapped delay chain
`include "memctl_macros.svh"

module memctl_burst_latency_shifter #(
	parameter int MAX_LATENCY  = `MEMCTL_MAX_LATENCY,
	parameter int BURST_LENGTH = `MEMCTL_BURST_LENGTH
) (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 d,
	output logic [MAX_LATENCY:0] q
);

	// Input pulse widened to cover a whole burst
	logic stretched;

	//////////////////////////////////////////////////////////////////////
	// Pulse stretcher
	//////////////////////////////////////////////////////////////////////

	generate
	if (BURST_LENGTH <= 1)
	begin : g_no_stretch
		// Single beat bursts need no widening
		assign stretched = d;
	end
	else
	begin : g_stretch
		localparam int SW = $clog2(BURST_LENGTH);

		// Beats still owed after the cycle of the pulse
		logic [SW-1:0] remain;

		// A new pulse reloads the count, so back to back bursts merge
		always_ff @(posedge clk or negedge reset_n)
		begin
			if (!reset_n)
				remain <= '0;
			else if (d)
				remain <= SW'(BURST_LENGTH - 1);
			else if (remain != '0)
				remain <= remain - 1'b1;
		end

		// High in the pulse cycle and the BURST_LENGTH-1 cycles after it
		assign stretched = d || (remain != '0);
	end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// Latency delay chain
	//////////////////////////////////////////////////////////////////////

	generate
	if (MAX_LATENCY == 0)
	begin : g_no_delay
		// Only the undelayed tap exists
		assign q = stretched;
	end
	else
	begin : g_delay
		// Stage k holds the stretched pulse from k cycles ago
		logic [MAX_LATENCY:1] chain;

		always_ff @(posedge clk or negedge reset_n)
		begin
			if (!reset_n)
				chain <= '0;
			else
			begin
				chain[1] <= stretched;
				for (int i = 2; i <= MAX_LATENCY; i++)
					chain[i] <= chain[i-1];
			end
		end

		// Tap 0 is combinational, the others come straight from the chain
		assign q = {chain, stretched};
	end
	endgenerate

endmodule

// File: rtl/memctl_read_group.sv
// Read data group with latency shifter, calibrated tap select and lane capture register
`include "memctl_macros.svh"

module memctl_read_group (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       rd_strobe,
	input  logic [`MEMCTL_LAT_W-1:0]   latency,
	input  memctl_pkg::lane_t          lane_in,
	output memctl_pkg::lane_beat_t     beat
);

	localparam int MAX_LAT = `MEMCTL_MAX_LATENCY;

	// Stretched read strobe at every delay from 0 to MAX_LAT
	logic [MAX_LAT:0]      taps;
	// Tap chosen by the calibrated latency
	logic                  tap_sel;
	logic                  beat_valid;
	memctl_pkg::lane_t     beat_data;

	//////////////////////////////////////////////////////////////////////
	// Latency shifter
	//////////////////////////////////////////////////////////////////////

	memctl_burst_latency_shifter #(
		.MAX_LATENCY  (MAX_LAT),
		.BURST_LENGTH (`MEMCTL_BURST_LENGTH)
	) shifter_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.d       (rd_strobe),
		.q       (taps)
	);

	//////////////////////////////////////////////////////////////////////
	// Tap select
	//////////////////////////////////////////////////////////////////////

	// A setting beyond MAX_LAT selects nothing, so such a group never captures
	always_comb
	begin
		tap_sel = 1'b0;
		for (int k = 0; k <= MAX_LAT; k++)
		begin
			if (int'(latency) == k)
				tap_sel = taps[k];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lane capture
	//////////////////////////////////////////////////////////////////////

	// The beat leaves here one cycle after it was at the pins
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			beat_valid <= 1'b0;
		else
			beat_valid <= tap_sel;
	end

	always_ff @(posedge clk)
	begin
		if (tap_sel)
			beat_data <= lane_in;
	end

	assign beat.valid = beat_valid;
	assign beat.data  = beat_data;

endmodule

// File: rtl/memctl_read_aligner.sv
// Deskew aligner with one beat FIFO per group, word release and sticky overflow flag
`include "memctl_macros.svh"

module memctl_read_aligner (
	input  logic                                              clk,
	input  logic                                              reset_n,
	input  memctl_pkg::lane_beat_t [`MEMCTL_NUM_GROUPS-1:0]   beats,
	output memctl_pkg::rd_out_t                               rd_out,
	output logic                                              overflow
);

	localparam int NG    = `MEMCTL_NUM_GROUPS;
	localparam int BL    = `MEMCTL_BURST_LENGTH;
	// Room for every burst that can be in flight across the latency spread
	localparam int DEPTH = BL * (`MEMCTL_MAX_LATENCY / BL + 1);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Group has a beat ready, either stored or arriving right now
	logic [NG-1:0]         avail;
	// Beat lost because the FIFO was full
	logic [NG-1:0]         ovf_hit;
	memctl_pkg::lane_t     head_data [NG];
	logic                  pop;
	logic                  out_valid;
	memctl_pkg::word_t     out_data;
	logic                  overflow_q;

	// All lanes of the oldest word are present
	assign pop = &avail;

	//////////////////////////////////////////////////////////////////////
	// Per group FIFOs
	//////////////////////////////////////////////////////////////////////

	generate
	for (genvar g = 0; g < NG; g++)
	begin : g_fifo
		memctl_pkg::lane_t     mem [DEPTH];
		logic [PTR_W-1:0]      wr_ptr;
		logic [PTR_W-1:0]      rd_ptr;
		logic [CNT_W-1:0]      count;
		logic                  empty;
		logic                  full;
		logic                  bypass;
		logic                  wr_en;
		logic                  rd_en;

		assign empty = (count == '0);
		assign full  = (count == CNT_W'(DEPTH));

		// An arriving beat may leave in the same cycle when nothing is queued
		assign avail[g]     = !empty || beats[g].valid;
		assign bypass       = pop && empty && beats[g].valid;
		assign wr_en        = beats[g].valid && !bypass && (!full || pop);
		assign rd_en        = pop && !empty;
		assign ovf_hit[g]   = beats[g].valid && full && !pop;
		assign head_data[g] = empty ? beats[g].data : mem[rd_ptr];

		always_ff @(posedge clk or negedge reset_n)
		begin
			if (!reset_n)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end
			else
			begin
				// Pointers wrap at DEPTH, which need not be a power of two
				if (wr_en)
					wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				if (rd_en)
					rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
			end
		end

		always_ff @(posedge clk)
		begin
			if (wr_en)
				mem[wr_ptr] <= beats[g].data;
		end
	end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// Word output and overflow
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			out_valid <= 1'b0;
		else
			out_valid <= pop;
	end

	// Lanes are gathered in group order, group 0 in the low bits
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			for (int i = 0; i < NG; i++)
				out_data[i] <= head_data[i];
		end
	end

	// Once data is lost the read stream can no longer be trusted
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			overflow_q <= 1'b0;
		else if (|ovf_hit)
			overflow_q <= 1'b1;
	end

	assign rd_out.valid = out_valid;
	assign rd_out.data  = out_data;
	assign overflow     = overflow_q;

endmodule

// File: rtl/memctl_top.sv
// Controller top with command issuer, generate loop of read groups and deskew aligner
`include "memctl_macros.svh"

module memctl_top (
	input  logic                     clk,
	input  logic                     reset_n,
	input  memctl_pkg::user_req_t    req,
	output logic                     ready,
	input  memctl_pkg::group_cfg_t   cfg,
	output memctl_pkg::mem_cmd_t     mem_cmd,
	input  memctl_pkg::word_t        mem_rdata,
	output memctl_pkg::rd_out_t      rd_out,
	output logic                     overflow
);

	// Read command marker shared by all groups
	logic                                                  rd_strobe;
	// Captured lane beats on their way to the aligner
	memctl_pkg::lane_beat_t [`MEMCTL_NUM_GROUPS-1:0]       group_beats;

	//////////////////////////////////////////////////////////////////////
	// Command issue
	//////////////////////////////////////////////////////////////////////

	memctl_cmd_issue cmd_issue_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.req       (req),
		.ready     (ready),
		.mem_cmd   (mem_cmd),
		.rd_strobe (rd_strobe)
	);

	//////////////////////////////////////////////////////////////////////
	// Data groups
	//////////////////////////////////////////////////////////////////////

	// Each group owns one lane of the return bus and one latency setting
	generate
	for (genvar g = 0; g < `MEMCTL_NUM_GROUPS; g++)
	begin : g_group
		memctl_read_group read_group_inst (
			.clk       (clk),
			.reset_n   (reset_n),
			.rd_strobe (rd_strobe),
			.latency   (cfg.latency[g]),
			.lane_in   (mem_rdata[g]),
			.beat      (group_beats[g])
		);
	end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// Deskew
	//////////////////////////////////////////////////////////////////////

	// Lanes arrive at different times and leave here as whole words
	memctl_read_aligner read_aligner_inst (
		.clk      (clk),
		.reset_n  (reset_n),
		.beats    (group_beats),
		.rd_out   (rd_out),
		.overflow (overflow)
	);

endmodule

// File: sim/tb_memctl.sv
// Testbench for the controller top with clock, reset, memory model, scoreboard, directed tests and summary
`include "memctl_macros.svh"

module tb_memctl;

	localparam int NG           = `MEMCTL_NUM_GROUPS;
	localparam int BL           = `MEMCTL_BURST_LENGTH;
	localparam int MAX_LAT      = `MEMCTL_MAX_LATENCY;
	localparam int ADDR_W       = `MEMCTL_ADDR_W;
	localparam int LAT_W        = `MEMCTL_LAT_W;
	localparam int NUM_ADDR     = 1 << ADDR_W;
	localparam int SCHED        = MAX_LAT + BL;
	localparam int RESET_CYCLES = 16;
	// Bursts per test: reset, write/read, deskew, back to back, spacing, random mix
	localparam int BURSTS       = 0 + 8 + 8 + 12 + 3 + 12;
	localparam int TIMEOUT      = BURSTS * (MAX_LAT + 2 * BL + 4) + RESET_CYCLES;

	logic                   clk = 1'b0;
	logic                   reset_n = 1'b0;
	memctl_pkg::user_req_t  req = '0;
	logic                   ready;
	memctl_pkg::group_cfg_t cfg = '0;
	memctl_pkg::mem_cmd_t   mem_cmd;
	memctl_pkg::word_t      mem_rdata = '0;
	memctl_pkg::rd_out_t    rd_out;
	logic                   overflow;

	// Memory contents by burst address and beat
	memctl_pkg::word_t      mem_model [NUM_ADDR][BL];
	// Lane data waiting to reach the pins, index 0 is the current cycle
	memctl_pkg::lane_t      sched [NG][SCHED];
	logic [ADDR_W-1:0]      wr_addr;
	int                     wr_beat = 0;
	logic                   wr_busy = 1'b0;
	// Requests the DUT has taken, oldest first, matched against the command bus
	memctl_pkg::user_req_t  req_q [$];
	// Request behind the command now on the bus
	memctl_pkg::user_req_t  cmd_exp;
	// Expected read words in issue order
	memctl_pkg::word_t      exp_q [$];
	// Cycle of each read command whose first word is still due
	int                     issue_q [$];
	int                     cycle = 0;
	int                     errors = 0;
	int                     tests_run = 0;
	int                     tests_ok = 0;
	int                     words_issued = 0;
	int                     words_seen = 0;
	int                     cmd_count = 0;
	int                     out_beat = 0;
	int                     run_len = 0;
	int                     last_delay = 0;
	logic [31:0]            rand_state = 32'h9a48dbcb;

	memctl_top memctl_top_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.req       (req),
		.ready     (ready),
		.cfg       (cfg),
		.mem_cmd   (mem_cmd),
		.mem_rdata (mem_rdata),
		.rd_out    (rd_out),
		.overflow  (overflow)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock and run limit
	//////////////////////////////////////////////////////////////////////

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycle++;
		if (cycle > TIMEOUT)
		begin
			$display("run stopped at cycle %0d because the DUT did not finish in time", cycle);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	// Runs just after the edge, where the command bus is settled
	always @(posedge clk)
	begin
		#1;
		for (int g = 0; g < NG; g++)
		begin
			for (int k = 0; k < SCHED - 1; k++)
				sched[g][k] = sched[g][k+1];
			sched[g][SCHED-1] = '0;
		end
		// Each command must match the oldest request taken by the DUT
		if (mem_cmd.rd || mem_cmd.wr)
		begin
			if (req_q.size() == 0)
			begin
				errors++;
				$display("a memory command appeared with no request to match it");
			end
			else
			begin
				cmd_exp = req_q.pop_front();
				check_flag("mem_cmd.rd", mem_cmd.rd, cmd_exp.rd && !cmd_exp.wr);
				check_flag("mem_cmd.wr", mem_cmd.wr, cmd_exp.wr);
				check_addr("mem_cmd.addr", mem_cmd.addr, cmd_exp.addr);
			end
		end
		// Write beats follow the command, one per cycle
		if (mem_cmd.wr)
		begin
			wr_addr = mem_cmd.addr;
			wr_beat = 0;
			wr_busy = 1'b1;
		end
		if (wr_busy)
		begin
			check_word("mem_cmd.wbeat", mem_cmd.wbeat, cmd_exp.wdata[wr_beat]);
			mem_model[wr_addr][wr_beat] = mem_cmd.wbeat;
			wr_beat++;
			if (wr_beat == BL)
				wr_busy = 1'b0;
		end
		// Beat b of lane g shows up latency[g]+b cycles after the read
		if (mem_cmd.rd)
		begin
			for (int b = 0; b < BL; b++)
			begin
				exp_q.push_back(mem_model[mem_cmd.addr][b]);
				for (int g = 0; g < NG; g++)
					sched[g][int'(cfg.latency[g]) + b] = mem_model[mem_cmd.addr][b][g];
			end
		end
		for (int g = 0; g < NG; g++)
			mem_rdata[g] = sched[g][0];
	end

	//////////////////////////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////////////////////////

	// Sampled mid cycle so every DUT output is stable
	always @(negedge clk)
	begin
		if (reset_n)
		begin
			if (mem_cmd.rd || mem_cmd.wr)
				cmd_count++;
			if (mem_cmd.rd)
				issue_q.push_back(cycle);
			if (rd_out.valid)
			begin
				// The first word of a burst closes the delay measurement
				if (out_beat == 0 && issue_q.size() != 0)
					last_delay = cycle - issue_q.pop_front();
				out_beat = (out_beat + 1) % BL;
				run_len++;
				words_seen++;
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("a read word arrived while no read was outstanding");
				end
				else
					check_word("rd_out.data", rd_out.data, exp_q.pop_front());
			end
			else if (run_len != 0)
			begin
				// Words of one burst must leave on consecutive cycles
				if (run_len % BL != 0)
				begin
					errors++;
					$display("a read burst was broken by a gap after %0d words", run_len);
				end
				run_len = 0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input memctl_pkg::word_t got,
		input memctl_pkg::word_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
		input logic [ADDR_W-1:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic memctl_pkg::word_t rand_word();
		memctl_pkg::word_t w;
		for (int g = 0; g < NG; g++)
			w[g] = memctl_pkg::lane_t'(next_rand() >> 7);
		return w;
	endfunction

	function automatic memctl_pkg::group_cfg_t rand_cfg();
		memctl_pkg::group_cfg_t c;
		for (int g = 0; g < NG; g++)
			c.latency[g] = LAT_W'(next_rand() % (MAX_LAT + 1));
		return c;
	endfunction

	// The slowest group sets when a whole word is available
	function automatic int max_latency(input memctl_pkg::group_cfg_t c);
		int m;
		m = 0;
		for (int g = 0; g < NG; g++)
			if (int'(c.latency[g]) > m)
				m = int'(c.latency[g]);
		return m;
	endfunction

	// Inputs change one time unit after the rising edge
	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	// Holds the request for the one cycle in which it is taken
	task automatic issue_burst(input memctl_pkg::user_req_t r);
		while (!ready)
			wait_cycle();
		req = r;
		req_q.push_back(r);
		if (r.rd && !r.wr)
			words_issued += BL;
		wait_cycle();
		req.rd = 1'b0;
		req.wr = 1'b0;
	endtask

	task automatic write_burst(input logic [ADDR_W-1:0] addr);
		memctl_pkg::user_req_t r;
		r = '0;
		r.wr = 1'b1;
		r.addr = addr;
		for (int b = 0; b < BL; b++)
			r.wdata[b] = rand_word();
		issue_burst(r);
	endtask

	task automatic read_burst(input logic [ADDR_W-1:0] addr);
		memctl_pkg::user_req_t r;
		r = '0;
		r.rd = 1'b1;
		r.addr = addr;
		issue_burst(r);
	endtask

	// Waits for every read word, then lets the tap chains run empty
	task automatic drain();
		while (words_seen != words_issued)
			wait_cycle();
		repeat (MAX_LAT + BL) wait_cycle();
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d expected read words never arrived", exp_q.size());
		end
		if (req_q.size() != 0)
		begin
			errors++;
			$display("%0d accepted requests never reached the command bus", req_q.size());
		end
	endtask

	task automatic report_test(input string name, input int e0);
		tests_run++;
		if (errors == e0)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
			$display("%s: %0d errors", name, errors - e0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_state_test();
		int e0;
		e0 = errors;
		check_flag("ready", ready, 1'b1);
		check_flag("rd_out.valid", rd_out.valid, 1'b0);
		check_flag("overflow", overflow, 1'b0);
		check_flag("mem_cmd.rd", mem_cmd.rd, 1'b0);
		check_flag("mem_cmd.wr", mem_cmd.wr, 1'b0);
		report_test("reset state", e0);
	endtask

	task automatic write_read_test();
		int e0;
		int lat;
		logic [ADDR_W-1:0] addrs [4];
		memctl_pkg::group_cfg_t c;
		e0 = errors;
		lat = int'(next_rand() % (MAX_LAT + 1));
		for (int g = 0; g < NG; g++)
			c.latency[g] = LAT_W'(lat);
		cfg = c;
		for (int i = 0; i < 4; i++)
		begin
			addrs[i] = ADDR_W'(next_rand());
			write_burst(addrs[i]);
		end
		// One read at a time so each delay is measured alone
		for (int i = 0; i < 4; i++)
		begin
			read_burst(addrs[i]);
			drain();
			check_count("read delay", last_delay, lat + 2);
		end
		report_test("write then read", e0);
	endtask

	task automatic deskew_test();
		int e0;
		logic [ADDR_W-1:0] a;
		memctl_pkg::group_cfg_t c;
		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			c = rand_cfg();
			cfg = c;
			a = ADDR_W'(next_rand());
			write_burst(a);
			read_burst(a);
			drain();
			check_count("read delay", last_delay, max_latency(c) + 2);
		end
		report_test("deskew", e0);
	endtask

	task automatic back_to_back_test();
		int e0;
		logic [ADDR_W-1:0] addrs [6];
		memctl_pkg::group_cfg_t c;
		e0 = errors;
		// Widest spread between groups fills the fastest FIFO the most
		c = rand_cfg();
		c.latency[0] = '0;
		c.latency[NG-1] = LAT_W'(MAX_LAT);
		cfg = c;
		for (int i = 0; i < 6; i++)
		begin
			addrs[i] = ADDR_W'(next_rand());
			write_burst(addrs[i]);
		end
		for (int i = 0; i < 6; i++)
			read_burst(addrs[i]);
		drain();
		check_flag("overflow", overflow, 1'b0);
		report_test("back to back", e0);
	endtask

	task automatic spacing_test();
		int e0;
		int n0;
		e0 = errors;
		n0 = cmd_count;
		req = '0;
		req.rd = 1'b1;
		req.addr = ADDR_W'(next_rand());
		// Only three of the held cycles find ready high
		for (int i = 0; i < 3; i++)
			req_q.push_back(req);
		// A held request is taken again only every BL cycles
		for (int i = 0; i < 3 * BL; i++)
		begin
			check_flag("ready", ready, (i % BL) == 0);
			wait_cycle();
		end
		req.rd = 1'b0;
		words_issued += 3 * BL;
		drain();
		check_count("mem_cmd strobes", cmd_count - n0, 3);
		report_test("spacing", e0);
	endtask

	task automatic random_mix_test();
		int e0;
		logic [ADDR_W-1:0] a;
		e0 = errors;
		for (int round = 0; round < 3; round++)
		begin
			cfg = rand_cfg();
			// A small address pool makes reads hit earlier writes
			for (int i = 0; i < 4; i++)
			begin
				a = ADDR_W'(32'h40 + next_rand() % 8);
				if (next_rand() >= 32'h8000_0000)
					write_burst(a);
				else
					read_burst(a);
			end
			drain();
		end
		check_flag("overflow", overflow, 1'b0);
		report_test("random mix", e0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		// Fill pattern carries the whole address and the beat
		for (int a = 0; a < NUM_ADDR; a++)
			for (int b = 0; b < BL; b++)
				mem_model[a][b] = memctl_pkg::word_t'({2'(b), 10'(a), 14'h2a5b, 10'(~a)});
		for (int g = 0; g < NG; g++)
			for (int k = 0; k < SCHED; k++)
				sched[g][k] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_n = 1'b1;
		wait_cycle();
		reset_state_test();
		write_read_test();
		deskew_test();
		back_to_back_test();
		spacing_test();
		random_mix_test();
		$display("tests run %0d, tests ok %0d, failed checks %0d", tests_run, tests_ok, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+rtl
rtl/memctl_pkg.sv
rtl/memctl_cmd_issue.sv
rtl/memctl_burst_latency_shifter.sv
rtl/memctl_read_group.sv
rtl/memctl_read_aligner.sv
rtl/memctl_top.sv
sim/tb_memctl.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_memctl -o tb_memctl
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_memctl)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# The verdict comes from the pass line in the simulation output
if printf '%s\n' "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
